// ==== filelist.f ====
+incdir+tb
design/dtcm_pkg.sv
design/dtcm_fifo.sv
design/dtcm_icb_arbiter.sv
design/dtcm_sram_ctrl.sv
design/dtcm_ram.sv
design/dtcm_ctrl.sv
tb/tb_dtcm_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DTCM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dtcm_ctrl \
  -f filelist.f -o sim_dtcm

# The run passes only if the simulation prints the pass line
./obj_dir/sim_dtcm | tee /dev/stderr | grep -x "Done: no errors" > /dev/null
echo "Simulation passed"

// ==== tb/tb_dtcm_tasks.svh ====
`ifndef TB_DTCM_TASKS_SVH
`define TB_DTCM_TASKS_SVH

function automatic dtcm_pkg::dtcm_cmd_t make_cmd(input logic read, input logic [15:0] addr,
                                                input logic [31:0] wdata,
                                                input logic [3:0] wmask);
  dtcm_pkg::dtcm_cmd_t cmd;
  cmd.read  = read;
  cmd.addr  = addr;
  cmd.wdata = wdata;
  cmd.wmask = wmask;
  return cmd;
endfunction

function automatic string port_name(input dtcm_pkg::dtcm_port_t port);
  return (port == dtcm_pkg::PORT_LSU) ? "LSU" : "EXT";
endfunction

// Writes and errors carry zero data while reads carry the reference word
function automatic logic [63:0] expected_rsp(input logic [15:0] addr, input logic err,
                                             input logic read);
  if (err || !read) return {31'b0, err, 32'b0};
  return {31'b0, 1'b0, ref_mem[addr[RAM_AW+1:2]]};
endfunction

task automatic check_value(input logic [63:0] expected, input logic [63:0] got,
                           input string msg);
  checks++;
  if (got !== expected) begin
    errors++;
    $display("error at %0t: %s, expected %0h, got %0h", $time, msg, expected, got);
  end
endtask

// Starts and ends on a falling edge with valid dropped at the end
task automatic send_cmd(input dtcm_pkg::dtcm_port_t port, input dtcm_pkg::dtcm_cmd_t cmd,
                        input int max_wait, input bit must_accept, output int acc_cycle);
  int   waited;
  logic ready;
  waited    = 0;
  ready     = 1'b0;
  acc_cycle = -1;
  if (port == dtcm_pkg::PORT_LSU) begin
    lsu_cmd       = cmd;
    lsu_cmd_valid = 1'b1;
  end else begin
    ext_cmd       = cmd;
    ext_cmd_valid = 1'b1;
  end
  while (!ready && waited < max_wait) begin
    #1;
    ready = (port == dtcm_pkg::PORT_LSU) ? lsu_cmd_ready : ext_cmd_ready;
    if (!ready) begin
      waited++;
      @(negedge clk);
    end
  end
  if (ready) begin
    acc_cycle = cycle_cnt + 1; // Transfer on the coming rising edge
    @(negedge clk);
  end else if (must_accept) begin
    errors++;
    $display("Timeout: the %s command was not accepted within %0d cycles",
             port_name(port), max_wait);
  end
  if (port == dtcm_pkg::PORT_LSU) lsu_cmd_valid = 1'b0;
  else ext_cmd_valid = 1'b0;
endtask

task automatic recv_rsp(input dtcm_pkg::dtcm_port_t port, output dtcm_pkg::dtcm_rsp_t rsp,
                        output int done_cycle);
  int   waited;
  logic valid;
  waited     = 0;
  valid      = 1'b0;
  rsp        = '0;
  done_cycle = -1;
  if (port == dtcm_pkg::PORT_LSU) lsu_rsp_ready = 1'b1;
  else ext_rsp_ready = 1'b1;
  while (!valid && waited < RSP_TIMEOUT) begin
    #1;
    valid = (port == dtcm_pkg::PORT_LSU) ? lsu_rsp_valid : ext_rsp_valid;
    if (!valid) begin
      waited++;
      @(negedge clk);
    end
  end
  if (valid) begin
    rsp        = (port == dtcm_pkg::PORT_LSU) ? lsu_rsp : ext_rsp;
    done_cycle = cycle_cnt + 1;
    @(negedge clk);
  end else begin
    errors++;
    $display("Timeout: no response on the %s port within %0d cycles",
             port_name(port), RSP_TIMEOUT);
  end
  if (port == dtcm_pkg::PORT_LSU) lsu_rsp_ready = 1'b0;
  else ext_rsp_ready = 1'b0;
endtask

task automatic write_word(input dtcm_pkg::dtcm_port_t port, input logic [15:0] addr,
                          input logic [31:0] data, input logic [3:0] mask, input logic err);
  dtcm_pkg::dtcm_rsp_t rsp;
  int                  acc;
  int                  done_at;
  send_cmd(port, make_cmd(1'b0, addr, data, mask), CMD_TIMEOUT, 1'b1, acc);
  recv_rsp(port, rsp, done_at);
  check_value(expected_rsp(addr, err, 1'b0), 64'(rsp), "write response");
  if (!err) begin
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) ref_mem[addr[RAM_AW+1:2]][b*8 +: 8] = data[b*8 +: 8]; // Masked merge
    end
  end
endtask

task automatic read_word(input dtcm_pkg::dtcm_port_t port, input logic [15:0] addr,
                         input logic err, output int latency);
  dtcm_pkg::dtcm_rsp_t rsp;
  int                  acc;
  int                  done_at;
  send_cmd(port, make_cmd(1'b1, addr, '0, '0), CMD_TIMEOUT, 1'b1, acc);
  recv_rsp(port, rsp, done_at);
  check_value(expected_rsp(addr, err, 1'b1), 64'(rsp), "read response");
  latency = done_at - acc;
endtask

`endif

// ==== tb/tb_dtcm_ctrl.sv ====
module tb_dtcm_ctrl;

  localparam int RAM_AW      = 10; // DUT defaults
  localparam int OUTS_NUM    = 2;
  localparam int CMD_TIMEOUT = 40;
  localparam int RSP_TIMEOUT = 40;

  logic                clk = 1'b0;
  logic                rst;
  logic                lsu_cmd_valid;
  logic                lsu_cmd_ready;
  dtcm_pkg::dtcm_cmd_t lsu_cmd;
  logic                lsu_rsp_valid;
  logic                lsu_rsp_ready;
  dtcm_pkg::dtcm_rsp_t lsu_rsp;
  logic                ext_cmd_valid;
  logic                ext_cmd_ready;
  dtcm_pkg::dtcm_cmd_t ext_cmd;
  logic                ext_rsp_valid;
  logic                ext_rsp_ready;
  dtcm_pkg::dtcm_rsp_t ext_rsp;
  logic                dtcm_active;
  logic [31:0]         ref_mem [2**RAM_AW]; // Unwritten words stay unknown
  integer              seed;
  int                  cycle_cnt = 0;
  int                  lsu_valid_seen = 0;
  int                  checks = 0;
  int                  errors = 0;
  int                  tests_run = 0;

  `include "tb_dtcm_tasks.svh"

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (lsu_rsp_valid) lsu_valid_seen <= lsu_valid_seen + 1; // Cycles with LSU rsp_valid high
  end

  dtcm_ctrl dut (
    .clk             (clk),
    .i_rst           (rst),
    .i_lsu_cmd_valid (lsu_cmd_valid),
    .o_lsu_cmd_ready (lsu_cmd_ready),
    .i_lsu_cmd       (lsu_cmd),
    .o_lsu_rsp_valid (lsu_rsp_valid),
    .i_lsu_rsp_ready (lsu_rsp_ready),
    .o_lsu_rsp       (lsu_rsp),
    .i_ext_cmd_valid (ext_cmd_valid),
    .o_ext_cmd_ready (ext_cmd_ready),
    .i_ext_cmd       (ext_cmd),
    .o_ext_rsp_valid (ext_rsp_valid),
    .i_ext_rsp_ready (ext_rsp_ready),
    .o_ext_rsp       (ext_rsp),
    .o_dtcm_active   (dtcm_active)
  );

  task automatic finish_test(input string name, input int start);
    tests_run++;
    $display("Test %s finished with %0d errors", name, errors - start);
  endtask

  task automatic verify_reset_state();
    int start;
    start = errors;
    check_value(0, lsu_rsp_valid, "LSU rsp_valid after reset");
    check_value(0, ext_rsp_valid, "EXT rsp_valid after reset");
    check_value(0, dtcm_active, "activity after reset");
    finish_test("reset_state", start);
  endtask

  task automatic lsu_write_read();
    int start;
    int lat;
    start = errors;
    write_word(dtcm_pkg::PORT_LSU, 16'h0010, $random(seed), 4'hf, 1'b0);
    write_word(dtcm_pkg::PORT_LSU, 16'h0014, $random(seed), 4'hf, 1'b0);
    read_word(dtcm_pkg::PORT_LSU, 16'h0010, 1'b0, lat);
    check_value(2, lat, "read latency into an empty pipeline");
    write_word(dtcm_pkg::PORT_LSU, 16'h0010, $random(seed), 4'b0101, 1'b0);
    write_word(dtcm_pkg::PORT_LSU, 16'h0014, $random(seed), 4'b1000, 1'b0);
    write_word(dtcm_pkg::PORT_LSU, 16'h0014, $random(seed), 4'b0010, 1'b0);
    read_word(dtcm_pkg::PORT_LSU, 16'h0010, 1'b0, lat);
    read_word(dtcm_pkg::PORT_LSU, 16'h0014, 1'b0, lat);
    finish_test("lsu_access", start);
  endtask

  task automatic ext_port_access();
    int start;
    int lat;
    int seen;
    start = errors;
    seen  = lsu_valid_seen;
    write_word(dtcm_pkg::PORT_EXT, 16'h0100, $random(seed), 4'hf, 1'b0);
    write_word(dtcm_pkg::PORT_EXT, 16'h0104, $random(seed), 4'hf, 1'b0);
    write_word(dtcm_pkg::PORT_EXT, 16'h0100, $random(seed), 4'b0110, 1'b0);
    read_word(dtcm_pkg::PORT_EXT, 16'h0100, 1'b0, lat);
    read_word(dtcm_pkg::PORT_EXT, 16'h0104, 1'b0, lat);
    check_value(seen, lsu_valid_seen, "LSU rsp_valid during EXT traffic");
    finish_test("ext_access", start);
  endtask

  task automatic same_cycle_arbitration();
    dtcm_pkg::dtcm_rsp_t rsp_l;
    dtcm_pkg::dtcm_rsp_t rsp_e;
    int                  start;
    int                  acc_l;
    int                  acc_e;
    int                  done_l;
    int                  done_e;
    start = errors;
    write_word(dtcm_pkg::PORT_LSU, 16'h0020, $random(seed), 4'hf, 1'b0);
    write_word(dtcm_pkg::PORT_EXT, 16'h0024, $random(seed), 4'hf, 1'b0);
    // Both masters request in the same cycle
    fork
      send_cmd(dtcm_pkg::PORT_LSU, make_cmd(1'b1, 16'h0020, '0, '0), CMD_TIMEOUT, 1'b1, acc_l);
      send_cmd(dtcm_pkg::PORT_EXT, make_cmd(1'b1, 16'h0024, '0, '0), CMD_TIMEOUT, 1'b1, acc_e);
    join
    check_value(1, acc_l < acc_e, "LSU accepted before EXT");
    fork
      recv_rsp(dtcm_pkg::PORT_LSU, rsp_l, done_l);
      recv_rsp(dtcm_pkg::PORT_EXT, rsp_e, done_e);
    join
    check_value(expected_rsp(16'h0020, 1'b0, 1'b1), 64'(rsp_l), "LSU read after arbitration");
    check_value(expected_rsp(16'h0024, 1'b0, 1'b1), 64'(rsp_e), "EXT read after arbitration");
    check_value(1, done_l < done_e, "responses in acceptance order");
    finish_test("arbitration", start);
  endtask

  task automatic response_back_pressure();
    dtcm_pkg::dtcm_rsp_t rsp_l;
    dtcm_pkg::dtcm_rsp_t rsp_e;
    int                  start;
    int                  acc_l;
    int                  acc_e;
    int                  acc_x;
    int                  done_l;
    int                  done_e;
    start = errors;
    // Both rsp_ready inputs are low between calls
    send_cmd(dtcm_pkg::PORT_LSU, make_cmd(1'b1, 16'h0010, '0, '0), CMD_TIMEOUT, 1'b1, acc_l);
    send_cmd(dtcm_pkg::PORT_EXT, make_cmd(1'b1, 16'h0100, '0, '0), CMD_TIMEOUT, 1'b1, acc_e);
    send_cmd(dtcm_pkg::PORT_LSU, make_cmd(1'b1, 16'h0014, '0, '0), 8, 1'b0, acc_x);
    check_value(0, acc_x >= 0, "LSU command accepted beyond OUTS_NUM");
    send_cmd(dtcm_pkg::PORT_EXT, make_cmd(1'b1, 16'h0104, '0, '0), 8, 1'b0, acc_x);
    check_value(0, acc_x >= 0, "EXT command accepted beyond OUTS_NUM");
    check_value(1, dtcm_active, "activity while responses are held");
    fork
      recv_rsp(dtcm_pkg::PORT_LSU, rsp_l, done_l);
      recv_rsp(dtcm_pkg::PORT_EXT, rsp_e, done_e);
    join
    check_value(expected_rsp(16'h0010, 1'b0, 1'b1), 64'(rsp_l), "LSU read after release");
    check_value(expected_rsp(16'h0100, 1'b0, 1'b1), 64'(rsp_e), "EXT read after release");
    check_value(1, done_l < done_e, "responses in order after release");
    #1;
    check_value(0, dtcm_active, "activity once the pipeline is idle");
    @(negedge clk);
    finish_test("back_pressure", start);
  endtask

  task automatic range_error_access();
    int start;
    int lat;
    start = errors;
    // 0x1010 aliases word 4 if the range check fails
    write_word(dtcm_pkg::PORT_LSU, 16'h1010, $random(seed), 4'hf, 1'b1);
    read_word(dtcm_pkg::PORT_LSU, 16'h1010, 1'b1, lat);
    read_word(dtcm_pkg::PORT_EXT, 16'h0010, 1'b0, lat);
    finish_test("range_error", start);
  endtask

  initial begin
    seed          = 32'ha7a2;
    rst           = 1'b1;
    lsu_cmd_valid = 1'b0;
    lsu_cmd       = '0;
    lsu_rsp_ready = 1'b0;
    ext_cmd_valid = 1'b0;
    ext_cmd       = '0;
    ext_rsp_ready = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    verify_reset_state();
    lsu_write_read();
    ext_port_access();
    same_cycle_arbitration();
    response_back_pressure();
    range_error_access();
    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== design/dtcm_ctrl.sv ====
module dtcm_ctrl #(
  parameter int RAM_AW   = 10,
  parameter int OUTS_NUM = 2
) (
  input  logic                clk,
  input  logic                i_rst,
  // LSU port
  input  logic                i_lsu_cmd_valid,
  output logic                o_lsu_cmd_ready,
  input  dtcm_pkg::dtcm_cmd_t i_lsu_cmd,
  output logic                o_lsu_rsp_valid,
  input  logic                i_lsu_rsp_ready,
  output dtcm_pkg::dtcm_rsp_t o_lsu_rsp,
  // External agent port
  input  logic                i_ext_cmd_valid,
  output logic                o_ext_cmd_ready,
  input  dtcm_pkg::dtcm_cmd_t i_ext_cmd,
  output logic                o_ext_rsp_valid,
  input  logic                i_ext_rsp_ready,
  output dtcm_pkg::dtcm_rsp_t o_ext_rsp,
  output logic                o_dtcm_active
);

  logic                             arb_valid;
  logic                             arb_ready;
  dtcm_pkg::dtcm_cmd_t              arb_cmd;
  dtcm_pkg::dtcm_port_t             arb_port;
  dtcm_pkg::dtcm_port_t             head_port; // Owner of the oldest response
  logic                             rsp_valid;
  logic                             rsp_ready;
  dtcm_pkg::dtcm_rsp_t              rsp;
  logic                             ram_cs;
  logic                             ram_we;
  logic [RAM_AW-1:0]                ram_addr;
  logic [dtcm_pkg::DTCM_WMSK_W-1:0] ram_wem;
  logic [dtcm_pkg::DTCM_DATA_W-1:0] ram_din;
  logic [dtcm_pkg::DTCM_DATA_W-1:0] ram_dout;
  logic                             ctrl_busy;

  dtcm_icb_arbiter u_arbiter (
    .i_lsu_valid (i_lsu_cmd_valid),
    .i_lsu_cmd   (i_lsu_cmd),
    .o_lsu_ready (o_lsu_cmd_ready),
    .i_ext_valid (i_ext_cmd_valid),
    .i_ext_cmd   (i_ext_cmd),
    .o_ext_ready (o_ext_cmd_ready),
    .o_valid     (arb_valid),
    .o_cmd       (arb_cmd),
    .o_port      (arb_port),
    .i_ready     (arb_ready)
  );

  // Port order FIFO as deep as the response FIFO so credit covers both
  dtcm_fifo #(
    .payload_t (dtcm_pkg::dtcm_port_t),
    .DEPTH     (OUTS_NUM)
  ) u_port_fifo (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_push  (arb_valid & arb_ready),
    .i_data  (arb_port),
    .o_full  (),
    .i_pop   (rsp_valid & rsp_ready),
    .o_data  (head_port),
    .o_empty (),
    .o_count ()
  );

  dtcm_sram_ctrl #(
    .RAM_AW   (RAM_AW),
    .OUTS_NUM (OUTS_NUM)
  ) u_sram_ctrl (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_cmd_valid (arb_valid),
    .i_cmd       (arb_cmd),
    .o_cmd_ready (arb_ready),
    .o_rsp_valid (rsp_valid),
    .o_rsp       (rsp),
    .i_rsp_ready (rsp_ready),
    .o_ram_cs    (ram_cs),
    .o_ram_we    (ram_we),
    .o_ram_addr  (ram_addr),
    .o_ram_wem   (ram_wem),
    .o_ram_din   (ram_din),
    .i_ram_dout  (ram_dout),
    .o_busy      (ctrl_busy)
  );

  dtcm_ram #(
    .RAM_AW (RAM_AW)
  ) u_ram (
    .clk    (clk),
    .i_cs   (ram_cs),
    .i_we   (ram_we),
    .i_addr (ram_addr),
    .i_wem  (ram_wem),
    .i_din  (ram_din),
    .o_dout (ram_dout)
  );

  // Steer the head response to the master that issued it
  assign o_lsu_rsp_valid = rsp_valid & (head_port == dtcm_pkg::PORT_LSU);
  assign o_ext_rsp_valid = rsp_valid & (head_port == dtcm_pkg::PORT_EXT);
  assign o_lsu_rsp       = rsp;
  assign o_ext_rsp       = rsp;
  assign rsp_ready = (head_port == dtcm_pkg::PORT_EXT) ? i_ext_rsp_ready : i_lsu_rsp_ready;

  assign o_dtcm_active = i_lsu_cmd_valid | i_ext_cmd_valid | ctrl_busy;

endmodule

// ==== design/dtcm_ram.sv ====
module dtcm_ram #(
  parameter int RAM_AW = 10
) (
  input  logic                             clk,
  input  logic                             i_cs,
  input  logic                             i_we,
  input  logic [RAM_AW-1:0]                i_addr,
  input  logic [dtcm_pkg::DTCM_WMSK_W-1:0] i_wem,
  input  logic [dtcm_pkg::DTCM_DATA_W-1:0] i_din,
  output logic [dtcm_pkg::DTCM_DATA_W-1:0] o_dout
);

  localparam int DEPTH = 2 ** RAM_AW;

  logic [dtcm_pkg::DTCM_DATA_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (i_cs) begin
      if (i_we) begin
        for (int b = 0; b < dtcm_pkg::DTCM_WMSK_W; b++) begin
          if (i_wem[b]) mem[i_addr][b*8 +: 8] <= i_din[b*8 +: 8]; // Byte lane write
        end
      end else begin
        o_dout <= mem[i_addr]; // Held until the next read
      end
    end
  end

endmodule

// ==== design/dtcm_sram_ctrl.sv ====
module dtcm_sram_ctrl #(
  parameter int RAM_AW   = 10,
  parameter int OUTS_NUM = 2
) (
  input  logic                               clk,
  input  logic                               i_rst,
  // Command from the arbiter
  input  logic                               i_cmd_valid,
  input  dtcm_pkg::dtcm_cmd_t                i_cmd,
  output logic                               o_cmd_ready,
  // Response toward the masters
  output logic                               o_rsp_valid,
  output dtcm_pkg::dtcm_rsp_t                o_rsp,
  input  logic                               i_rsp_ready,
  // SRAM port
  output logic                               o_ram_cs,
  output logic                               o_ram_we,
  output logic [RAM_AW-1:0]                  o_ram_addr,
  output logic [dtcm_pkg::DTCM_WMSK_W-1:0]   o_ram_wem,
  output logic [dtcm_pkg::DTCM_DATA_W-1:0]   o_ram_din,
  input  logic [dtcm_pkg::DTCM_DATA_W-1:0]   i_ram_dout,
  output logic                               o_busy
);

  localparam int CNT_W  = $clog2(OUTS_NUM + 1);
  localparam int WORD_H = RAM_AW + dtcm_pkg::DTCM_AW_LSB; // First byte address bit above RAM

  logic                cmd_hsk;
  logic                addr_err;
  logic                inf_vld;  // Access issued last cycle
  logic                inf_err;
  logic                inf_rd;
  logic [CNT_W:0]      used;     // Buffered plus in flight
  dtcm_pkg::dtcm_rsp_t rsp_in;
  logic                rsp_push;
  logic                rsp_pop;
  logic                rsp_full;
  logic                rsp_empty;
  logic [CNT_W-1:0]    rsp_count;

  assign used        = {1'b0, rsp_count} + (CNT_W + 1)'(inf_vld);
  assign o_cmd_ready = (used < (CNT_W + 1)'(OUTS_NUM)); // Credit check
  assign cmd_hsk     = i_cmd_valid & o_cmd_ready;

  // Any address bit above the RAM range makes it an error
  assign addr_err = |(i_cmd.addr >> WORD_H);

  // Access starts in the handshake cycle
  assign o_ram_cs   = cmd_hsk & ~addr_err;
  assign o_ram_we   = o_ram_cs & ~i_cmd.read;
  assign o_ram_addr = i_cmd.addr[WORD_H-1:dtcm_pkg::DTCM_AW_LSB];
  assign o_ram_wem  = i_cmd.wmask & {dtcm_pkg::DTCM_WMSK_W{o_ram_we}};
  assign o_ram_din  = i_cmd.wdata;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      inf_vld <= 1'b0;
    end else begin
      inf_vld <= cmd_hsk; // Errors also take a slot
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_hsk) begin
      inf_err <= addr_err;
      inf_rd  <= i_cmd.read;
    end
  end

  // RAM dout is valid the cycle after cs
  always_comb begin
    rsp_in.err   = inf_err;
    rsp_in.rdata = (inf_rd && !inf_err) ? i_ram_dout : '0;
  end

  assign rsp_push = inf_vld;
  assign rsp_pop  = o_rsp_valid & i_rsp_ready;

  dtcm_fifo #(
    .payload_t (dtcm_pkg::dtcm_rsp_t),
    .DEPTH     (OUTS_NUM)
  ) u_rsp_fifo (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_push  (rsp_push),
    .i_data  (rsp_in),
    .o_full  (rsp_full),
    .i_pop   (rsp_pop),
    .o_data  (o_rsp),
    .o_empty (rsp_empty),
    .o_count (rsp_count)
  );

  assign o_rsp_valid = ~rsp_empty;
  assign o_busy      = inf_vld | ~rsp_empty;

  // Credit keeps room in the response FIFO for every access in flight
  a_credit_room: assert property (@(posedge clk) disable iff (i_rst)
    inf_vld |-> !rsp_full);

endmodule

// ==== design/dtcm_icb_arbiter.sv ====
module dtcm_icb_arbiter (
  // LSU command channel with priority
  input  logic                 i_lsu_valid,
  input  dtcm_pkg::dtcm_cmd_t  i_lsu_cmd,
  output logic                 o_lsu_ready,
  // External agent command channel
  input  logic                 i_ext_valid,
  input  dtcm_pkg::dtcm_cmd_t  i_ext_cmd,
  output logic                 o_ext_ready,
  // Granted command toward the SRAM controller
  output logic                 o_valid,
  output dtcm_pkg::dtcm_cmd_t  o_cmd,
  output dtcm_pkg::dtcm_port_t o_port,
  input  logic                 i_ready
);

  logic lsu_win;

  // LSU wins whenever it asks
  assign lsu_win = i_lsu_valid;

  assign o_valid = i_lsu_valid | i_ext_valid;
  assign o_cmd   = lsu_win ? i_lsu_cmd : i_ext_cmd;
  assign o_port  = lsu_win ? dtcm_pkg::PORT_LSU : dtcm_pkg::PORT_EXT;

  // Ready goes back to the winner only
  assign o_lsu_ready = i_ready & lsu_win;
  assign o_ext_ready = i_ready & ~lsu_win; // EXT holds the grant while LSU is idle

endmodule

// ==== design/dtcm_fifo.sv ====
module dtcm_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic                       clk,
  input  logic                       i_rst,
  input  logic                       i_push,
  input  payload_t                   i_data,
  output logic                       o_full,
  input  logic                       i_pop,
  output payload_t                   o_data,
  output logic                       o_empty,
  output logic [$clog2(DEPTH+1)-1:0] o_count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t             mem [DEPTH];
  logic     [PTR_W-1:0] wr_ptr;
  logic     [PTR_W-1:0] rd_ptr;
  logic     [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap at DEPTH
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (i_push && !i_pop) count <= count + 1'b1;
      else if (!i_push && i_pop) count <= count - 1'b1;
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (i_push) mem[wr_ptr] <= i_data;
  end

  assign o_data  = mem[rd_ptr]; // Head entry shows whenever not empty
  assign o_empty = (count == '0);
  assign o_full  = (count == CNT_W'(DEPTH));
  assign o_count = count;

  a_no_overflow: assert property (@(posedge clk) disable iff (i_rst) !(i_push && o_full));
  a_no_underflow: assert property (@(posedge clk) disable iff (i_rst) !(i_pop && o_empty));

endmodule

// ==== design/dtcm_pkg.sv ====
package dtcm_pkg;

  // Bus widths of the ICB side
  localparam int DTCM_ADDR_W = 16; // Byte address
  localparam int DTCM_DATA_W = 32;
  localparam int DTCM_WMSK_W = DTCM_DATA_W / 8; // One bit per byte lane
  localparam int DTCM_AW_LSB = 2; // Word aligned 32-bit data

  // Command beat as seen by the SRAM controller
  typedef struct packed {
    logic                   read;  // Set for a read, clear for a write
    logic [DTCM_ADDR_W-1:0] addr;
    logic [DTCM_DATA_W-1:0] wdata;
    logic [DTCM_WMSK_W-1:0] wmask;
  } dtcm_cmd_t;

  // Response beat, one per accepted command
  typedef struct packed {
    logic                   err;   // Address out of range
    logic [DTCM_DATA_W-1:0] rdata; // Zero for writes and errors
  } dtcm_rsp_t;

  // Master that issued a command
  typedef enum logic {
    PORT_LSU = 1'b0,
    PORT_EXT = 1'b1
  } dtcm_port_t;

endpackage
